//--- project.f
nocPkg.sv
flitFifo.sv
packetTimer.sv
portArbiter.sv
outputLink.sv
routerOutputPort.sv
routerChecks_props.sv
tbRouterOutputPort.sv

//--- run.sh
#!/bin/sh
# compiles and runs the router output port testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f project.f --top-module tbRouterOutputPort
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

output=$(./obj_dir/VtbRouterOutputPort)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "test passed"; then
  exit 0
fi
exit 1

//--- tbRouterOutputPort.sv
`timescale 1ns/1ps

module tbRouterOutputPort;
  import nocPkg::*;

  localparam int FifoDepth  = 8;
  localparam int OutCredits = 4;
  localparam int WaitLimit  = 5000;

  logic                clk;
  logic                rst;
  flit_t               inFlit [NumPorts];
  logic [NumPorts-1:0] inValid;
  logic [NumPorts-1:0] creditOut;
  flit_t               outFlit;
  logic                outValid;
  logic                creditIn;

  int    seed;
  int    errors;
  int    checks;
  int    testErrors;
  int    pktSeq;
  int    cycle;

  // upstream senders and expected traffic, per direction.
  flit_t sendQ [NumPorts][$];
  flit_t expQ [NumPorts][$];
  int    upCredits [NumPorts];
  int    creditsBack [NumPorts];
  int    pendingPkts [NumPorts];

  // downstream receiver.
  int    dueQ [$];
  logic  holdCredits;
  logic  slowCredits;
  int    creditsReturned;
  int    outValidCount;

  // packet reassembly.
  int    remaining;
  int    curSrc;
  int    lastSrc;
  logic  rotCheck;
  int    deliveredPkts;
  int    receivedFlits;
  int    sentFlits;

  routerOutputPort #(
    .FifoDepth  (FifoDepth),
    .OutCredits (OutCredits)
  ) UUT (
    .clk       (clk),
    .rst       (rst),
    .inFlit    (inFlit),
    .inValid   (inValid),
    .creditOut (creditOut),
    .outFlit   (outFlit),
    .outValid  (outValid),
    .creditIn  (creditIn)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // next owner by rotation, the port just served comes last.
  function automatic int nextSource(input int prevSrc, input logic [NumPorts-1:0] pending);
    int idx;
    for (int i = 1; i <= NumPorts; i++)
    begin
      idx = (prevSrc + i) % NumPorts;
      if (pending[idx])
        return idx;
    end
    return -1;
  endfunction

  function automatic int randLen(input int lo, input int hi);
    return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
  endfunction

  task automatic reportMismatch(input string msg);
    errors++;
    testErrors++;
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
  endtask

  task automatic abortRun(input string msg);
    $display("%s", msg);
    $display("test failed");
    $finish;
  endtask

  task automatic sendPacket(input int src, input int len);
    flit_t f;
    f.kind    = FLIT_HEAD;
    f.length  = LenW'(len);
    f.payload = {4'(src), 12'(pktSeq), 16'(0)};
    sendQ[src].push_back(f);
    expQ[src].push_back(f);
    for (int i = 1; i < len; i++)
    begin
      f.kind    = (i == len - 1) ? FLIT_TAIL : FLIT_BODY;
      f.length  = '0;
      f.payload = {4'(src), 12'(pktSeq), 16'(i)};
      sendQ[src].push_back(f);
      expQ[src].push_back(f);
    end
    pktSeq++;
    pendingPkts[src]++;
    sentFlits += len;
  endtask

  task automatic scoreFlit(input flit_t f);
    flit_t               exp;
    int                  src;
    int                  want;
    logic [NumPorts-1:0] mask;
    checks++;
    receivedFlits++;
    if (remaining == 0)
    begin
      src = int'(f.payload[31:28]);
      if (f.kind != FLIT_HEAD)
      begin
        reportMismatch($sformatf("expected a header, got kind %0d", f.kind));
        return;
      end
      if (src >= NumPorts || expQ[src].size() == 0)
      begin
        reportMismatch($sformatf("header from unexpected source %0d", src));
        return;
      end
      if (rotCheck)
      begin
        for (int p = 0; p < NumPorts; p++)
          mask[p] = (pendingPkts[p] > 0);
        want = nextSource(lastSrc, mask);
        if (src != want)
          reportMismatch($sformatf("packet source %0d, expected %0d", src, want));
      end
      lastSrc   = src;
      curSrc    = src;
      remaining = int'(f.length);
    end
    exp = expQ[curSrc].pop_front();
    if (f != exp)
      reportMismatch($sformatf("flit %h, expected %h", f, exp));
    remaining--;
    if (remaining == 0)
    begin
      pendingPkts[curSrc]--;
      deliveredPkts++;
    end
  endtask

  // ==========================================================================
  // upstream senders and downstream receiver.
  // ==========================================================================
  always @(negedge clk)
  begin
    int d;
    int due;
    cycle++;
    for (int p = 0; p < NumPorts; p++)
    begin
      if (creditOut[p])
      begin
        upCredits[p]++;
        creditsBack[p]++;
      end
      inValid[p] = 1'b0;
      if (!rst && sendQ[p].size() > 0 && upCredits[p] > 0)
      begin
        inFlit[p]  = sendQ[p].pop_front();
        inValid[p] = 1'b1;
        upCredits[p]--;
      end
    end
    if (!rst && outValid)
    begin
      outValidCount++;
      if (outValidCount > OutCredits + creditsReturned)
        reportMismatch("outValid with no downstream credit left");
      d   = slowCredits ? randLen(2, 9) : randLen(0, 3);
      due = cycle + d;
      if (dueQ.size() > 0 && due < dueQ[$])
        due = dueQ[$];
      dueQ.push_back(due);
    end
    creditIn = 1'b0;
    if (!holdCredits && dueQ.size() > 0 && dueQ[0] <= cycle)
    begin
      creditIn = 1'b1;
      void'(dueQ.pop_front());
      creditsReturned++;
    end
  end

  // compare.
  always @(negedge clk)
  begin
    if (!rst && outValid)
      scoreFlit(outFlit);
  end

  task automatic waitDelivered(input int target);
    int n;
    n = 0;
    while (deliveredPkts < target)
    begin
      @(negedge clk);
      n++;
      if (n > WaitLimit)
        abortRun($sformatf("timeout: %0d of %0d packets delivered", deliveredPkts, target));
    end
  endtask

  task automatic waitSendDrained();
    int n;
    n = 0;
    while (sendQ[0].size() + sendQ[1].size() + sendQ[2].size() + sendQ[3].size()
           + sendQ[4].size() > 0)
    begin
      @(negedge clk);
      n++;
      if (n > WaitLimit)
        abortRun("timeout: upstream senders never emptied their queues");
    end
  endtask

  task automatic waitCredits(input int p, input int target);
    int n;
    n = 0;
    while (creditsBack[p] < target)
    begin
      @(negedge clk);
      n++;
      if (n > WaitLimit)
        abortRun($sformatf("timeout: port %0d got %0d credits back", p, creditsBack[p]));
    end
  endtask

  task automatic endTest(input int num, input string name);
    if (testErrors == 0)
      $display("test %0d %s: ok", num, name);
    else
      $display("test %0d %s: FAILED with %0d errors", num, name, testErrors);
    testErrors = 0;
  endtask

  // ==========================================================================
  // test sequence.
  // ==========================================================================
  initial
  begin
    int p;
    int len;
    int base;
    int target;
    seed = 32'h5492;
    errors = 0;
    checks = 0;
    testErrors = 0;
    pktSeq = 0;
    cycle = 0;
    holdCredits = 1'b0;
    slowCredits = 1'b0;
    creditsReturned = 0;
    outValidCount = 0;
    remaining = 0;
    curSrc = 0;
    lastSrc = int'(PORT_S);
    rotCheck = 1'b0;
    deliveredPkts = 0;
    receivedFlits = 0;
    sentFlits = 0;
    rst = 1'b1;
    inValid = '0;
    creditIn = 1'b0;
    for (int i = 0; i < NumPorts; i++)
    begin
      inFlit[i] = '0;
      upCredits[i] = FifoDepth;
      creditsBack[i] = 0;
      pendingPkts[i] = 0;
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // idle outputs through the first cycle out of reset.
    for (int i = 0; i < 2; i++)
    begin
      if (i == 0)
        @(posedge clk);
      else
        @(negedge clk);
      #1;
      checks++;
      if (outValid !== 1'b0 || creditOut !== '0)
        reportMismatch("outValid or creditOut active right after reset");
    end
    endTest(1, "reset state");

    p = randLen(0, NumPorts - 1);
    len = randLen(2, 6);
    base = creditsBack[p];
    target = deliveredPkts + 1;
    sendPacket(p, len);
    waitDelivered(target);
    waitCredits(p, base + len);
    repeat (5) @(negedge clk);
    checks++;
    if (creditsBack[p] != base + len)
      reportMismatch($sformatf("port %0d got %0d credits for %0d flits",
                               p, creditsBack[p] - base, len));
    endTest(2, "single packet");

    target = deliveredPkts + NumPorts;
    for (int i = 0; i < NumPorts; i++)
      sendPacket(i, randLen(2, 6));
    waitDelivered(target);
    endTest(3, "all directions");

    holdCredits = 1'b1;
    rotCheck = 1'b1;
    lastSrc = int'(PORT_S);
    target = deliveredPkts + 2 * NumPorts;
    for (int k = 0; k < 2; k++)
      for (int i = 0; i < NumPorts; i++)
        sendPacket(i, randLen(2, 4));
    waitSendDrained();
    repeat (4) @(negedge clk);
    holdCredits = 1'b0;
    waitDelivered(target);
    rotCheck = 1'b0;
    endTest(4, "rotation");

    slowCredits = 1'b1;
    target = deliveredPkts + 2 * NumPorts;
    for (int k = 0; k < 2; k++)
      for (int i = 0; i < NumPorts; i++)
        sendPacket(i, randLen(2, 6));
    waitDelivered(target);
    repeat (10) @(negedge clk);
    checks++;
    if (receivedFlits != sentFlits)
      reportMismatch($sformatf("received %0d flits, sent %0d", receivedFlits, sentFlits));
    for (int i = 0; i < NumPorts; i++)
    begin
      checks++;
      if (expQ[i].size() != 0)
        reportMismatch($sformatf("port %0d has %0d flits never delivered", i, expQ[i].size()));
    end
    slowCredits = 1'b0;
    endTest(5, "back-pressure");

    $display("totals: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

  // overall limit on run time.
  initial
  begin
    #(40 * 200000);
    abortRun("simulation ran too long and was stopped");
  end

endmodule

//--- routerChecks_props.sv
`timescale 1ns/1ps

module routerChecks #(
  parameter int OutCredits = 4
) (
  input logic                        clk,
  input logic                        rst,
  input logic [nocPkg::NumPorts-1:0] pop,
  input logic [nocPkg::NumPorts-1:0] notEmpty,
  input logic [nocPkg::NumPorts-1:0] lastFlit,
  input logic                        creditIn,
  input logic                        outValid
);
  import nocPkg::*;

  logic [NumPorts-1:0] ownerPop;
  logic                midPacket;
  int                  linkCredits;

  // tracks who is in the middle of a packet.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      ownerPop  <= '0;
      midPacket <= 1'b0;
    end
    else if (|pop)
    begin
      ownerPop  <= pop;
      midPacket <= !(|(pop & lastFlit));
    end
  end

  // credits as the downstream receiver sees them.
  always_ff @(posedge clk)
  begin
    if (rst)
      linkCredits <= OutCredits;
    else
      linkCredits <= linkCredits + int'(creditIn) - int'(outValid);
  end

  popOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(pop))
    else $error("pop has more than one bit set");

  popNotEmpty: assert property (@(posedge clk) disable iff (rst) (pop & ~notEmpty) == '0)
    else $error("pop on an empty buffer");

  outValidCredit: assert property (@(posedge clk) disable iff (rst)
    outValid |-> (linkCredits > 0))
    else $error("outValid with no downstream credit");

  ownerHeld: assert property (@(posedge clk) disable iff (rst)
    (midPacket && |pop) |-> (pop == ownerPop))
    else $error("owner switched before the last flit");

endmodule

bind routerOutputPort routerChecks #(
  .OutCredits (OutCredits)
) uChecks (
  .clk       (clk),
  .rst       (rst),
  .pop       (pop),
  .notEmpty  (notEmpty),
  .lastFlit  (lastFlit),
  .creditIn  (creditIn),
  .outValid  (outValid)
);

//--- routerOutputPort.sv
`timescale 1ns/1ps

module routerOutputPort #(
  parameter int FifoDepth  = 8,
  parameter int OutCredits = 4
) (
  input  logic                        clk,
  input  logic                        rst,
  input  nocPkg::flit_t               inFlit [nocPkg::NumPorts],
  input  logic [nocPkg::NumPorts-1:0] inValid,
  output logic [nocPkg::NumPorts-1:0] creditOut,
  output nocPkg::flit_t               outFlit,
  output logic                        outValid,
  input  logic                        creditIn
);
  import nocPkg::*;

  flit_t               headFlits [NumPorts];
  logic [NumPorts-1:0] notEmpty;
  logic [NumPorts-1:0] pop;
  logic [NumPorts-1:0] lastFlit;
  logic                hasCredit;

  // ==========================================================================
  // per-direction buffer and packet timer.
  // ==========================================================================
  for (genvar p = 0; p < NumPorts; p++)
  begin : dirGen
    flitFifo #(
      .FifoDepth (FifoDepth)
    ) uFifo (
      .clk       (clk),
      .rst       (rst),
      .inFlit    (inFlit[p]),
      .inValid   (inValid[p]),
      .pop       (pop[p]),
      .headFlit  (headFlits[p]),
      .notEmpty  (notEmpty[p]),
      .creditOut (creditOut[p])
    );

    packetTimer uTimer (
      .clk      (clk),
      .rst      (rst),
      .headFlit (headFlits[p]),
      .pop      (pop[p]),
      .lastFlit (lastFlit[p])
    );
  end

  // ==========================================================================
  // arbiter and output link.
  // ==========================================================================
  portArbiter uArbiter (
    .clk       (clk),
    .rst       (rst),
    .notEmpty  (notEmpty),
    .hasCredit (hasCredit),
    .lastFlit  (lastFlit),
    .pop       (pop)
  );

  outputLink #(
    .OutCredits (OutCredits)
  ) uLink (
    .clk       (clk),
    .rst       (rst),
    .pop       (pop),
    .headFlits (headFlits),
    .creditIn  (creditIn),
    .outFlit   (outFlit),
    .outValid  (outValid),
    .hasCredit (hasCredit)
  );

endmodule

//--- outputLink.sv
`timescale 1ns/1ps

module outputLink #(
  parameter int OutCredits = 4
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [nocPkg::NumPorts-1:0] pop,
  input  nocPkg::flit_t               headFlits [nocPkg::NumPorts],
  input  logic                        creditIn,
  output nocPkg::flit_t               outFlit,
  output logic                        outValid,
  output logic                        hasCredit
);
  import nocPkg::*;

  localparam int CntW = $clog2(OutCredits + 1);

  logic [CntW-1:0] creditCount;
  flit_t           selFlit;
  logic            anyPop;

  // one-hot select of the popped head.
  always_comb
  begin
    selFlit = '0;
    for (int p = 0; p < NumPorts; p++)
    begin
      if (pop[p])
        selFlit = headFlits[p];
    end
  end

  assign anyPop = |pop;

  always_ff @(posedge clk)
  begin
    if (anyPop)
      outFlit <= selFlit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid    <= 1'b0;
      creditCount <= CntW'(OutCredits);
    end
    else
    begin
      outValid <= anyPop;
      case ({anyPop, creditIn})
        2'b10:   creditCount <= creditCount - 1'b1;
        2'b01:   creditCount <= creditCount + 1'b1;
        default: creditCount <= creditCount;
      endcase
    end
  end

  assign hasCredit = (creditCount != '0);

endmodule

//--- portArbiter.sv
`timescale 1ns/1ps

module portArbiter (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [nocPkg::NumPorts-1:0] notEmpty,
  input  logic                        hasCredit,
  input  logic [nocPkg::NumPorts-1:0] lastFlit,
  output logic [nocPkg::NumPorts-1:0] pop
);
  import nocPkg::*;

  arbState_e           state;
  arbState_e           nextState;
  portId_e             owner;
  logic                ownerValid;
  logic [NumPorts-1:0] ownerMask;
  logic                packetDone;

  // ==========================================================================
  // rotating search.
  // ==========================================================================

  // first requester at or after start wins.
  function automatic arbState_e pickFrom(
    input logic [NumPorts-1:0] req,
    input int                  start
  );
    arbState_e pick;
    int        idx;
    pick = ARB_IDLE;
    for (int i = NumPorts - 1; i >= 0; i--)
    begin
      idx = (start + i) % NumPorts;
      if (req[idx])
        pick = arbState_e'(6'b000010 << idx);
    end
    return pick;
  endfunction

  // ==========================================================================
  // owner decode and pop.
  // ==========================================================================
  always_comb
  begin
    ownerValid = 1'b1;
    owner      = PORT_L;
    case (state)
      ARB_L:   owner = PORT_L;
      ARB_N:   owner = PORT_N;
      ARB_E:   owner = PORT_E;
      ARB_W:   owner = PORT_W;
      ARB_S:   owner = PORT_S;
      default: ownerValid = 1'b0;
    endcase
  end

  always_comb
  begin
    ownerMask = '0;
    if (ownerValid)
      ownerMask[owner] = 1'b1;
  end

  // owner keeps the grant through empty or creditless cycles.
  assign pop = (hasCredit && |(ownerMask & notEmpty)) ? ownerMask : '0;

  assign packetDone = |(pop & lastFlit);

  // ==========================================================================
  // next state.
  // ==========================================================================
  always_comb
  begin
    nextState = state;
    if (!ownerValid)
      nextState = pickFrom(notEmpty, int'(PORT_L));
    else if (packetDone)
      // port just served drops out and re-enters through idle.
      nextState = pickFrom(notEmpty & ~ownerMask, int'(owner) + 1);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= ARB_IDLE;
    else
      state <= nextState;
  end

endmodule

//--- packetTimer.sv
`timescale 1ns/1ps

module packetTimer (
  input  logic          clk,
  input  logic          rst,
  input  nocPkg::flit_t headFlit,
  input  logic          pop,
  output logic          lastFlit
);
  import nocPkg::*;

  logic [LenW-1:0] pktLen;
  logic [LenW-1:0] sentCount;
  logic            isHead;

  assign isHead = (headFlit.kind == FLIT_HEAD);

  // counts forwarded flits, not cycles.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pktLen    <= '0;
      sentCount <= '0;
    end
    else if (pop)
    begin
      if (isHead)
      begin
        pktLen    <= headFlit.length;
        sentCount <= LenW'(1);
      end
      else if (lastFlit)
        sentCount <= '0;
      else
        sentCount <= sentCount + 1'b1;
    end
  end

  assign lastFlit = pop && !isHead && (sentCount == pktLen - 1'b1);

endmodule

//--- flitFifo.sv
`timescale 1ns/1ps

module flitFifo #(
  parameter int FifoDepth = 8
) (
  input  logic          clk,
  input  logic          rst,
  input  nocPkg::flit_t inFlit,
  input  logic          inValid,
  input  logic          pop,
  output nocPkg::flit_t headFlit,
  output logic          notEmpty,
  output logic          creditOut
);
  import nocPkg::*;

  localparam int PtrW = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;

  flit_t           mem [FifoDepth];
  logic [PtrW-1:0] rdPtr;
  logic [PtrW-1:0] wrPtr;
  logic [PtrW:0]   count;

  // storage, written whenever the sender pushes.
  always_ff @(posedge clk)
  begin
    if (inValid)
      mem[wrPtr] <= inFlit;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rdPtr     <= '0;
      wrPtr     <= '0;
      count     <= '0;
      creditOut <= 1'b0;
    end
    else
    begin
      if (inValid)
        wrPtr <= (wrPtr == PtrW'(FifoDepth - 1)) ? '0 : wrPtr + 1'b1;
      if (pop)
        rdPtr <= (rdPtr == PtrW'(FifoDepth - 1)) ? '0 : rdPtr + 1'b1;
      case ({inValid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // one credit back upstream per dequeued flit.
      creditOut <= pop;
    end
  end

  assign headFlit = mem[rdPtr];
  assign notEmpty = (count != '0);

endmodule

//--- nocPkg.sv
package nocPkg;

  // ==========================================================================
  // router dimensions and field widths.
  // ==========================================================================
  localparam int NumPorts = 5;
  localparam int LenW = 12;
  localparam int PayloadW = 32;

  // flit type code carried in every flit.
  typedef enum logic [2:0] {
    FLIT_HEAD = 3'd1,
    FLIT_BODY = 3'd2,
    FLIT_TAIL = 3'd3
  } flitKind_e;

  // input directions in rotation order.
  typedef enum logic [2:0] {
    PORT_L = 3'd0,
    PORT_N = 3'd1,
    PORT_E = 3'd2,
    PORT_W = 3'd3,
    PORT_S = 3'd4
  } portId_e;

  // one-hot arbiter states, owner bit is port index plus one.
  typedef enum logic [5:0] {
    ARB_IDLE = 6'b000001,
    ARB_L    = 6'b000010,
    ARB_N    = 6'b000100,
    ARB_E    = 6'b001000,
    ARB_W    = 6'b010000,
    ARB_S    = 6'b100000
  } arbState_e;

  // length counts all flits of the packet, header included.
  typedef struct packed {
    flitKind_e           kind;
    logic [LenW-1:0]     length;
    logic [PayloadW-1:0] payload;
  } flit_t;

endpackage
